// File: rtl/cpe_defines.svh
`ifndef CPE_DEFINES_SVH
`define CPE_DEFINES_SVH

// complex word format
// each part is two's complement
`define CPE_DATA_W      16
`define CPE_FRAC_W      8

// register file and program store sizes
`define CPE_REG_NUM     16
`define CPE_REG_AW      ($clog2(`CPE_REG_NUM))
`define CPE_PROG_DEPTH  16
`define CPE_PC_W        ($clog2(`CPE_PROG_DEPTH))

// output stream credits
`define CPE_CREDITS     4
`define CPE_CREDIT_W    ($clog2(`CPE_CREDITS + 1))

`endif

// File: rtl/cpe_pkg.sv
`include "cpe_defines.svh"

package cpe_pkg;

    // one complex data word
    typedef struct packed {
        logic signed [`CPE_DATA_W-1:0] re;
        logic signed [`CPE_DATA_W-1:0] im;
    } cplx_t;

    // alu operations plus end of program
    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_MUL   = 3'd2,
        OP_CMULC = 3'd3,
        OP_HALT  = 3'd4
    } opcode_e;

    // sequencer states
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_RUN   = 2'd1,
        ST_DRAIN = 2'd2,
        ST_DONE  = 2'd3
    } run_state_e;

    // program word as stored in inst_mem
    typedef struct packed {
        opcode_e                 opcode;
        logic [`CPE_REG_AW-1:0]  dst;
        logic [`CPE_REG_AW-1:0]  src_a;
        logic [`CPE_REG_AW-1:0]  src_b;
        logic                    emit;
    } inst_t;

    // stage 1 issue register
    typedef struct packed {
        logic                    valid;
        opcode_e                 opcode;
        logic [`CPE_REG_AW-1:0]  dst;
        logic [`CPE_REG_AW-1:0]  src_a;
        logic [`CPE_REG_AW-1:0]  src_b;
        logic                    emit;
    } issue_t;

    // stage 2 operand register
    typedef struct packed {
        logic                    valid;
        opcode_e                 opcode;
        logic [`CPE_REG_AW-1:0]  dst;
        logic                    emit;
        cplx_t                   a;
        cplx_t                   b;
    } operand_t;

    // stage 4 result, write-back and stream
    typedef struct packed {
        logic                    valid;
        logic [`CPE_REG_AW-1:0]  dst;
        logic                    emit;
        cplx_t                   value;
    } result_t;

endpackage

// File: rtl/inst_mem.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module inst_mem
    import cpe_pkg::*;
(
    input  logic                   clk,
    input  logic                   prog_we,
    input  logic [`CPE_PC_W-1:0]   prog_addr,
    input  inst_t                  prog_inst,
    input  logic [`CPE_PC_W-1:0]   pc,
    output inst_t                  inst
);

    // program store
    inst_t mem [`CPE_PROG_DEPTH];

    // host write port
    // only used while the element is idle
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_inst;
        end
    end

    // async read at pc
    // lets control hold pc on a stall with no refetch bubble
    assign inst = mem[pc];

endmodule

// File: rtl/pe_control.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module pe_control
    import cpe_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   credit_return,
    input  inst_t                  inst,
    output logic [`CPE_PC_W-1:0]   pc,
    output issue_t                 issue,
    output logic                   busy,
    output logic                   done
);

    localparam int CW = `CPE_CREDIT_W;
    localparam logic [CW-1:0] CREDIT_MAX = `CPE_CREDITS;

    run_state_e              state;
    logic [CW-1:0]           credits;

    // scoreboard of in-flight destinations
    // entry 0 issue reg, 1 operand stage, 2 alu stage 3
    logic [2:0]              sb_valid;
    logic [`CPE_REG_AW-1:0]  sb_dst [3];

    logic                    is_halt;
    logic                    hazard;
    logic                    no_credit;
    logic                    fire;
    logic                    take;

    ////////////////////////////////////////////////////////////
    // issue decision
    ////////////////////////////////////////////////////////////

    assign is_halt = (inst.opcode == OP_HALT);

    // raw hazard on either source
    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (sb_valid[i] &&
                (sb_dst[i] == inst.src_a || sb_dst[i] == inst.src_b)) begin
                hazard = 1'b1;
            end
        end
    end

    // emitting op needs a credit in hand
    assign no_credit = inst.emit && (credits == '0);
    assign fire      = (state == ST_RUN) && !is_halt && !hazard && !no_credit;
    assign take      = fire && inst.emit;

    ////////////////////////////////////////////////////////////
    // run fsm and pc
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= ST_RUN;
                        pc    <= '0;
                    end
                end
                ST_RUN: begin
                    // halt stays out of the pipe
                    if (is_halt) begin
                        state <= ST_DRAIN;
                    end else if (fire) begin
                        pc <= pc + 1'b1;
                    end
                end
                // last result sits in stage 4 when scoreboard empties
                ST_DRAIN: begin
                    if (sb_valid == '0) begin
                        state <= ST_DONE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign busy = (state == ST_RUN) || (state == ST_DRAIN);
    assign done = (state == ST_DONE);

    ////////////////////////////////////////////////////////////
    // credits, issue register, scoreboard
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credits <= CREDIT_MAX;
        end else begin
            case ({take, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue.valid <= 1'b0;
            sb_valid    <= '0;
        end else begin
            issue.valid <= fire;
            sb_valid    <= {sb_valid[1:0], fire};
            if (fire) begin
                issue.opcode <= inst.opcode;
                issue.dst    <= inst.dst;
                issue.src_a  <= inst.src_a;
                issue.src_b  <= inst.src_b;
                issue.emit   <= inst.emit;
            end
        end
    end

    // dst shift follows sb_valid
    always_ff @(posedge clk) begin
        sb_dst[0] <= inst.dst;
        sb_dst[1] <= sb_dst[0];
        sb_dst[2] <= sb_dst[1];
    end

endmodule

// File: rtl/data_mem.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module data_mem
    import cpe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    data_we,
    input  logic [`CPE_REG_AW-1:0]  data_addr,
    input  cplx_t                   data_word,
    input  issue_t                  issue,
    input  result_t                 wb,
    output operand_t                operand
);

    // complex register file
    cplx_t rf [`CPE_REG_NUM];

    logic                    we;
    logic [`CPE_REG_AW-1:0]  waddr;
    cplx_t                   wdata;
    cplx_t                   rd_a;
    cplx_t                   rd_b;

    ////////////////////////////////////////////////////////////
    // shared write port
    ////////////////////////////////////////////////////////////

    // write-back wins, host loads only while idle
    assign we    = wb.valid || data_we;
    assign waddr = wb.valid ? wb.dst : data_addr;
    assign wdata = wb.valid ? wb.value : data_word;

    always_ff @(posedge clk) begin
        if (we) begin
            rf[waddr] <= wdata;
        end
    end

    // write-first bypass on both reads
    always_comb begin
        rd_a = (we && waddr == issue.src_a) ? wdata : rf[issue.src_a];
        rd_b = (we && waddr == issue.src_b) ? wdata : rf[issue.src_b];
    end

    ////////////////////////////////////////////////////////////
    // stage 2 operand register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            operand.valid <= 1'b0;
        end else begin
            operand.valid <= issue.valid;
        end
    end

    // payload follows issue every cycle
    always_ff @(posedge clk) begin
        operand.opcode <= issue.opcode;
        operand.dst    <= issue.dst;
        operand.emit   <= issue.emit;
        operand.a      <= rd_a;
        operand.b      <= rd_b;
    end

endmodule

// File: rtl/complex_alu.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module complex_alu
    import cpe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  operand_t  operand,
    output result_t   result
);

    localparam int W    = `CPE_DATA_W;
    localparam int PW   = 2 * W;
    localparam int FRAC = `CPE_FRAC_W;

    // stage 3 register
    logic                    s3_valid;
    opcode_e                 s3_op;
    logic [`CPE_REG_AW-1:0]  s3_dst;
    logic                    s3_emit;
    logic signed [PW-1:0]    s3_term [4];

    logic signed [PW-1:0]    term_d [4];
    logic signed [W-1:0]     part [4];
    logic                    s3_is_mul;
    cplx_t                   sum_d;

    ////////////////////////////////////////////////////////////
    // stage 3 cross products or pass-through
    ////////////////////////////////////////////////////////////

    // slots 0..3 hold rr, ii, ri, ir for the multiply ops
    // and ar, br, ai, bi for add and sub
    always_comb begin
        case (operand.opcode)
            OP_MUL, OP_CMULC: begin
                term_d[0] = operand.a.re * operand.b.re;
                term_d[1] = operand.a.im * operand.b.im;
                term_d[2] = operand.a.re * operand.b.im;
                term_d[3] = operand.a.im * operand.b.re;
            end
            default: begin
                term_d[0] = PW'(operand.a.re);
                term_d[1] = PW'(operand.b.re);
                term_d[2] = PW'(operand.a.im);
                term_d[3] = PW'(operand.b.im);
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s3_valid <= 1'b0;
        end else begin
            s3_valid <= operand.valid;
        end
    end

    always_ff @(posedge clk) begin
        s3_op   <= operand.opcode;
        s3_dst  <= operand.dst;
        s3_emit <= operand.emit;
        s3_term <= term_d;
    end

    ////////////////////////////////////////////////////////////
    // stage 4 combine
    ////////////////////////////////////////////////////////////

    assign s3_is_mul = (s3_op == OP_MUL) || (s3_op == OP_CMULC);

    // products rescaled by arithmetic shift then truncated
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            if (s3_is_mul) begin
                part[k] = W'(s3_term[k] >>> FRAC);
            end else begin
                part[k] = s3_term[k][W-1:0];
            end
        end
    end

    // all sums wrap at W bits
    always_comb begin
        case (s3_op)
            OP_MUL: begin
                sum_d.re = part[0] - part[1];
                sum_d.im = part[2] + part[3];
            end
            // a times conj(b)
            OP_CMULC: begin
                sum_d.re = part[0] + part[1];
                sum_d.im = part[3] - part[2];
            end
            OP_SUB: begin
                sum_d.re = part[0] - part[1];
                sum_d.im = part[2] - part[3];
            end
            default: begin
                sum_d.re = part[0] + part[1];
                sum_d.im = part[2] + part[3];
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= s3_valid;
        end
    end

    always_ff @(posedge clk) begin
        result.dst   <= s3_dst;
        result.emit  <= s3_emit;
        result.value <= sum_d;
    end

endmodule

// File: rtl/cpe_top.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module cpe_top
    import cpe_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    // host program load
    input  logic                    prog_we,
    input  logic [`CPE_PC_W-1:0]    prog_addr,
    input  inst_t                   prog_inst,
    // host data load
    input  logic                    data_we,
    input  logic [`CPE_REG_AW-1:0]  data_addr,
    input  cplx_t                   data_word,
    // run control
    input  logic                    start,
    output logic                    busy,
    output logic                    done,
    // credit stream
    input  logic                    credit_return,
    output logic                    out_valid,
    output cplx_t                   out_data
);

    logic [`CPE_PC_W-1:0]  pc;
    inst_t                 inst;
    issue_t                issue;
    operand_t              operand;
    result_t               result;

    // program store
    inst_mem inst_mem_i (
        .clk       (clk),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_inst (prog_inst),
        .pc        (pc),
        .inst      (inst)
    );

    // fetch and issue, stage 1
    pe_control pe_control_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .credit_return (credit_return),
        .inst          (inst),
        .pc            (pc),
        .issue         (issue),
        .busy          (busy),
        .done          (done)
    );

    // operand read, stage 2
    data_mem data_mem_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_we   (data_we),
        .data_addr (data_addr),
        .data_word (data_word),
        .issue     (issue),
        .wb        (result),
        .operand   (operand)
    );

    // multiply and combine, stages 3 and 4
    complex_alu complex_alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .operand (operand),
        .result  (result)
    );

    // only emitting results reach the stream
    assign out_valid = result.valid && result.emit;
    assign out_data  = result.value;

endmodule

// File: tb/cpe_tb.sv
`timescale 1ns/10ps
`include "cpe_defines.svh"

module cpe_tb
    import cpe_pkg::*;
();

    localparam logic [31:0] SEED = 32'hb3f8c8f0;
    // per-run wait for done and for the stream to drain
    localparam int RUN_WAIT = 300;
    // six tests of well under 600 cycles each plus reset and slack
    localparam int CYCLE_LIMIT = 6 * 600 + 400;

    logic                    clk;
    logic                    rst_n;
    logic                    prog_we;
    logic [`CPE_PC_W-1:0]    prog_addr;
    inst_t                   prog_inst;
    logic                    data_we;
    logic [`CPE_REG_AW-1:0]  data_addr;
    cplx_t                   data_word;
    logic                    start;
    logic                    busy;
    logic                    done;
    logic                    credit_return;
    logic                    out_valid;
    cplx_t                   out_data;

    // reference register file and expected stream
    cplx_t  model_rf [`CPE_REG_NUM];
    cplx_t  exp_q [$];

    int     prog_len;
    int     errors;
    int     tests_failed;
    int     words_rx;
    int     credits_tx;
    int     done_seen;
    int     cycles;
    int     sink_wait;
    logic   sink_hold;

    cpe_top cpe_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .prog_we       (prog_we),
        .prog_addr     (prog_addr),
        .prog_inst     (prog_inst),
        .data_we       (data_we),
        .data_addr     (data_addr),
        .data_word     (data_word),
        .start         (start),
        .busy          (busy),
        .done          (done),
        .credit_return (credit_return),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run length guard
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reporting and reference arithmetic
    ////////////////////////////////////////////////////////////

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    function automatic cplx_t make_cplx(input logic [15:0] re, input logic [15:0] im);
        cplx_t c;
        c.re = re;
        c.im = im;
        return c;
    endfunction

    function automatic cplx_t rand_cplx();
        logic [31:0] r;
        r = $urandom();
        return make_cplx(r[15:0], r[31:16]);
    endfunction

    // product rescale by arithmetic shift of the fraction bits
    function automatic int rescale(input int p);
        return p >>> `CPE_FRAC_W;
    endfunction

    // sums formed wide and wrapped by the final truncation
    function automatic cplx_t expect_op(input opcode_e op, input cplx_t a, input cplx_t b);
        int ar;
        int ai;
        int br;
        int bi;
        int sre;
        int sim;
        cplx_t r;
        ar = a.re;
        ai = a.im;
        br = b.re;
        bi = b.im;
        case (op)
            OP_ADD: begin
                sre = ar + br;
                sim = ai + bi;
            end
            OP_SUB: begin
                sre = ar - br;
                sim = ai - bi;
            end
            OP_MUL: begin
                sre = rescale(ar * br) - rescale(ai * bi);
                sim = rescale(ar * bi) + rescale(ai * br);
            end
            // a * conj(b)
            OP_CMULC: begin
                sre = rescale(ar * br) + rescale(ai * bi);
                sim = rescale(ai * br) - rescale(ar * bi);
            end
            default: begin
                sre = 0;
                sim = 0;
            end
        endcase
        r.re = sre[`CPE_DATA_W-1:0];
        r.im = sim[`CPE_DATA_W-1:0];
        return r;
    endfunction

    ////////////////////////////////////////////////////////////
    // stream monitor and credit sink
    ////////////////////////////////////////////////////////////

    // stream check and done count at mid-cycle
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            words_rx++;
            if (exp_q.size() == 0) begin
                flag_error("output word arrived with nothing expected");
            end else begin
                check_eq("out_data", out_data, exp_q[0]);
                void'(exp_q.pop_front());
            end
        end
        if (rst_n && done) begin
            done_seen++;
        end
        assert (words_rx - credits_tx <= `CPE_CREDITS) else
            flag_error("more words outstanding than the credit limit allows");
    end

    // one credit back per word after a random delay
    // sink_hold withholds all credits
    always begin
        @(posedge clk);
        #1;
        credit_return = 1'b0;
        if (!sink_hold && (words_rx - credits_tx) > 0) begin
            if (sink_wait == 0) begin
                credit_return = 1'b1;
                credits_tx++;
                sink_wait = $urandom_range(3, 0);
            end else begin
                sink_wait--;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // host load and run tasks
    ////////////////////////////////////////////////////////////

    task automatic write_reg(input int addr, input cplx_t value);
        @(posedge clk);
        #1;
        data_we   = 1'b1;
        data_addr = addr[`CPE_REG_AW-1:0];
        data_word = value;
        model_rf[addr] = value;
    endtask

    // appends to the program and steps the reference model
    task automatic put_inst(input opcode_e op, input int dst, input int src_a,
                            input int src_b, input logic emit);
        inst_t w;
        cplx_t r;
        w.opcode = op;
        w.dst    = dst[`CPE_REG_AW-1:0];
        w.src_a  = src_a[`CPE_REG_AW-1:0];
        w.src_b  = src_b[`CPE_REG_AW-1:0];
        w.emit   = emit;
        @(posedge clk);
        #1;
        data_we   = 1'b0;
        prog_we   = 1'b1;
        prog_addr = prog_len[`CPE_PC_W-1:0];
        prog_inst = w;
        prog_len++;
        if (op != OP_HALT) begin
            r = expect_op(op, model_rf[src_a], model_rf[src_b]);
            model_rf[dst] = r;
            if (emit) begin
                exp_q.push_back(r);
            end
        end
    endtask

    task automatic start_program(output int done_before);
        done_before = done_seen;
        @(posedge clk);
        #1;
        prog_we  = 1'b0;
        data_we  = 1'b0;
        start    = 1'b1;
        @(posedge clk);
        #1;
        start    = 1'b0;
        prog_len = 0;
        // busy rises the cycle after start
        check_eq("busy", 32'(busy), 1);
    endtask

    task automatic wait_done(input int done_before);
        int n;
        n = 0;
        while (done_seen == done_before && n < RUN_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (done_seen == done_before) begin
            flag_error("done never pulsed after start");
        end
        n = 0;
        while ((exp_q.size() != 0 || words_rx != credits_tx) && n < RUN_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            flag_error("expected output words never arrived");
            exp_q.delete();
        end
        if (words_rx != credits_tx) begin
            flag_error("credit sink did not settle");
        end
        repeat (3) @(negedge clk);
        check_eq("done_pulses", done_seen - done_before, 1);
        check_eq("busy", 32'(busy), 0);
    endtask

    task automatic report_test(input int num, input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL (%0d errors)", num, name, errors - err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int db;
        int base;
        int err0;
        rst_n         = 1'b0;
        prog_we       = 1'b0;
        prog_addr     = '0;
        prog_inst     = '0;
        data_we       = 1'b0;
        data_addr     = '0;
        data_word     = '0;
        start         = 1'b0;
        credit_return = 1'b0;
        sink_hold     = 1'b0;
        sink_wait     = 0;
        prog_len      = 0;
        errors        = 0;
        tests_failed  = 0;
        words_rx      = 0;
        credits_tx    = 0;
        done_seen     = 0;
        void'($urandom(SEED));
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // test 1 quiet after reset
        err0 = errors;
        repeat (20) begin
            @(negedge clk);
            check_eq("out_valid", 32'(out_valid), 0);
            check_eq("busy", 32'(busy), 0);
            check_eq("done", 32'(done), 0);
        end
        report_test(1, "reset state", err0);

        // test 2 add and sub with wrap at both ends
        err0 = errors;
        for (int i = 0; i < 4; i++) begin
            write_reg(i, rand_cplx());
        end
        write_reg(4, make_cplx(16'h7fff, 16'h8000));
        write_reg(5, make_cplx(16'h0001, 16'hffff));
        put_inst(OP_ADD, 8, 0, 1, 1'b1);
        put_inst(OP_SUB, 9, 2, 3, 1'b1);
        put_inst(OP_ADD, 10, 4, 5, 1'b1);
        put_inst(OP_SUB, 11, 5, 4, 1'b1);
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        start_program(db);
        wait_done(db);
        report_test(2, "add and sub", err0);

        // test 3 fixed-point multiplies
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            write_reg(i, rand_cplx());
        end
        put_inst(OP_MUL, 6, 0, 1, 1'b1);
        put_inst(OP_CMULC, 7, 2, 3, 1'b1);
        put_inst(OP_MUL, 8, 4, 5, 1'b1);
        put_inst(OP_CMULC, 9, 0, 5, 1'b1);
        put_inst(OP_MUL, 10, 1, 1, 1'b1);
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        start_program(db);
        wait_done(db);
        report_test(3, "mul and cmulc", err0);

        // test 4 dependent chain where only the tail emits
        err0 = errors;
        write_reg(0, rand_cplx());
        write_reg(1, rand_cplx());
        put_inst(OP_MUL, 2, 0, 1, 1'b0);
        put_inst(OP_ADD, 3, 2, 1, 1'b0);
        put_inst(OP_CMULC, 4, 3, 0, 1'b0);
        put_inst(OP_SUB, 5, 4, 2, 1'b0);
        put_inst(OP_MUL, 6, 5, 5, 1'b1);
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        start_program(db);
        wait_done(db);
        report_test(4, "dependent chain", err0);

        // test 5 eight emits against a withheld credit sink
        err0 = errors;
        for (int i = 0; i < 8; i++) begin
            write_reg(i, rand_cplx());
        end
        for (int i = 0; i < 8; i++) begin
            put_inst(OP_ADD, 8 + i, i, 7 - i, 1'b1);
        end
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        sink_hold = 1'b1;
        base = words_rx;
        start_program(db);
        for (int n = 0; n < RUN_WAIT && (words_rx - base) < `CPE_CREDITS; n++) begin
            @(posedge clk);
        end
        // element must sit on its last credit
        repeat (20) @(negedge clk);
        check_eq("words_without_credit", words_rx - base, `CPE_CREDITS);
        sink_hold = 1'b0;
        wait_done(db);
        check_eq("words_total", words_rx - base, 8);
        report_test(5, "credit back-pressure", err0);

        // test 6 halt then a second program
        err0 = errors;
        write_reg(0, rand_cplx());
        write_reg(1, rand_cplx());
        put_inst(OP_MUL, 2, 0, 1, 1'b1);
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        start_program(db);
        wait_done(db);
        write_reg(3, rand_cplx());
        put_inst(OP_CMULC, 4, 3, 2, 1'b1);
        put_inst(OP_SUB, 5, 4, 0, 1'b1);
        put_inst(OP_HALT, 0, 0, 0, 1'b0);
        start_program(db);
        wait_done(db);
        report_test(6, "halt and rerun", err0);

        $display("summary: 6 tests, %0d failed, %0d errors", tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/cpe_pkg.sv
rtl/inst_mem.sv
rtl/pe_control.sv
rtl/data_mem.sv
rtl/complex_alu.sv
rtl/cpe_top.sv
tb/cpe_tb.sv
